//--- files.f
src/aes_key_pkg.sv
src/key_expander.sv
src/key_store.sv
src/key_block.sv
dv/tb_key_block.sv

//--- run_sim.sh
#!/bin/sh
# Builds the key schedule testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_key_block -o tb_key_block -f files.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_key_block > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
	exit 1
fi

if ! grep -q "Simulation finished: PASS" "$SIM_LOG"; then
	echo "Simulation log has no final verdict"
	exit 1
fi

exit 0

//--- dv/key_golden.hex
// Four vectors of twelve 128-bit words, one word per line
// Per vector: cipher key, then round keys 0 to 10
// FIPS-197 example key
2b7e151628aed2a6abf7158809cf4f3c
2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605
f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b
ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc
6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f
ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e
d014f9a8c9ee2589e13f0cc8b6630ca6
// All zeros
00000000000000000000000000000000
00000000000000000000000000000000
62636363626363636263636362636363
9b9898c9f9fbfbaa9b9898c9f9fbfbaa
90973450696ccffaf2f457330b0fac99
ee06da7b876a1581759e42b27e91ee2b
7f2e2b88f8443e098dda7cbbf34b9290
ec614b851425758c99ff09376ab49ba7
217517873550620bacaf6b3cc61bf09b
0ef903333ba9613897060a04511dfa9f
b1d4d8e28a7db9da1d7bb3de4c664941
b4ef5bcb3e92e21123e951cf6f8f188e
// All ones
ffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffff
e8e9e9e917161616e8e9e9e917161616
adaeae19bab8b80f525151e6454747f0
090e2277b3b69a78e1e7cb9ea4a08c6e
e16abd3e52dc2746b33becd8179b60b6
e5baf3ceb766d488045d385013c658e6
71d07db3c6b6a93bc2eb916bd12dc98d
e90d208d2fbb89b6ed5018dd3c7dd150
96337366b988fad054d8e20d68a5335d
8bf03f233278c5f366a027fe0e0514a3
d60a3588e472f07b82d2d7858cd7c326
// Counting bytes 00 to 0f
000102030405060708090a0b0c0d0e0f
000102030405060708090a0b0c0d0e0f
d6aa74fdd2af72fadaa678f1d6ab76fe
b692cf0b643dbdf1be9bc5006830b3fe
b6ff744ed2c2c9bf6c590cbf0469bf41
47f7f7bc95353e03f96c32bcfd058dfd
3caaa3e8a99f9deb50f3af57adf622aa
5e390f7df7a69296a7553dc10aa31f6b
14f9701ae35fe28c440adf4d4ea9c026
47438735a41c65b9e016baf4aebf7ad2
549932d1f08557681093ed9cbe2c974e
13111d7fe3944a17f307a78b4d2b30c5

//--- dv/tb_key_block.sv
// Run from the project root so dv/key_golden.hex is found; vector 3 must stay last in the file
`timescale 1ns/10ps

module tb_key_block
	import aes_key_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_VEC = 4;
	localparam int WORDS_PER_VEC = 12;
	localparam int TEST_CYCLES = 40;
	// Generous bound over the cycle count of all tests
	localparam int TIMEOUT_NS = NUM_VEC * TEST_CYCLES * CLK_PERIOD * 2;

	logic                   tb_clk;
	logic                   rst;
	logic                   load;
	logic [127:0]           in;
	logic [ROUND_IDX_W-1:0] select;
	logic                   ready;
	logic [127:0]           round_key;
	logic [127:0]           fround_key;

	logic [127:0] golden [0:NUM_VEC*WORDS_PER_VEC-1];
	logic [31:0]  lfsr_state;
	int           check_count;
	int           err_count;
	int           test_err_base;

	key_block i_dut (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.load       (load),
		.in         (in),
		.select     (select),
		.ready      (ready),
		.round_key  (round_key),
		.fround_key (fround_key)
	);

	always #(CLK_PERIOD / 2) tb_clk = ~tb_clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int nbits, output int value);
		value = 0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("ERR %s got %h expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string what);
		check_count++;
		err_count++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic finish_test(input int num, input string name);
		$display("Test %0d %s finished with %0d errors", num, name, err_count - test_err_base);
		test_err_base = err_count;
	endtask

	// Pulse load for one cycle, returns at the falling edge after the sampling edge
	task automatic load_key(input logic [127:0] key);
		@(negedge tb_clk);
		load = 1'b1;
		in = key;
		@(negedge tb_clk);
		load = 1'b0;
	endtask

	// Ready is due exactly ten falling edges after load_key returns
	task automatic wait_ready();
		int cyc;
		cyc = 0;
		while (!ready && cyc <= NUM_ROUNDS + 2)
		begin
			@(negedge tb_clk);
			cyc++;
		end
		if (!ready)
			report_failure("ready never rose after the key was loaded");
		else if (cyc < NUM_ROUNDS)
			report_failure("ready rose before the expansion could have finished");
		else if (cyc > NUM_ROUNDS)
			report_failure("ready rose later than the end of the expansion");
	endtask

	// Outputs for a select appear one cycle after it is driven
	task automatic check_select(input int vec, input int sel);
		int           base;
		logic [127:0] exp_fwd;
		logic [127:0] exp_rev;
		base = vec * WORDS_PER_VEC + 1;
		if (sel > NUM_ROUNDS)
		begin
			exp_fwd = '0;
			exp_rev = '0;
		end
		else
		begin
			exp_fwd = golden[base + sel];
			exp_rev = golden[base + NUM_ROUNDS - sel];
		end
		@(negedge tb_clk);
		select = ROUND_IDX_W'(sel);
		@(negedge tb_clk);
		check($sformatf("round_key[select=%0d]", sel), round_key, exp_fwd);
		check($sformatf("fround_key[select=%0d]", sel), fround_key, exp_rev);
	endtask

	task automatic run_vector(input int vec);
		load_key(golden[vec * WORDS_PER_VEC]);
		wait_ready();
		for (int sel = 0; sel <= NUM_ROUNDS; sel++)
			check_select(vec, sel);
	endtask

	// Give up if some wait never ends
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int order [0:NUM_ROUNDS];
		int r;
		int j;
		int tmp;
		int delay;

		tb_clk = 1'b0;
		rst = 1'b1;
		load = 1'b0;
		in = '0;
		select = '0;
		lfsr_state = 32'hf5cb6ede;
		check_count = 0;
		err_count = 0;
		test_err_base = 0;
		$readmemh("dv/key_golden.hex", golden);

		repeat (2) @(negedge tb_clk);
		rst = 1'b0;
		@(negedge tb_clk);
		check("ready", 128'(ready), 128'(0));
		check("round_key", round_key, '0);
		check("fround_key", fround_key, '0);
		finish_test(1, "reset");

		run_vector(0);
		finish_test(2, "FIPS-197 expansion");

		for (int v = 1; v < NUM_VEC; v++)
			run_vector(v);
		finish_test(3, "other golden keys");

		// Shuffle of all selects over the schedule of the last vector
		for (int i = 0; i <= NUM_ROUNDS; i++)
			order[i] = i;
		for (int i = NUM_ROUNDS; i > 0; i--)
		begin
			take_bits(8, r);
			j = r % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i <= NUM_ROUNDS; i++)
			check_select(NUM_VEC - 1, order[i]);
		finish_test(4, "random select order");

		// Key A is the zero key, key B replaces it mid expansion
		take_bits(4, r);
		delay = 1 + r % 9;
		load_key(golden[1 * WORDS_PER_VEC]);
		for (int k = 1; k < delay; k++)
		begin
			@(negedge tb_clk);
			if (ready)
				report_failure("ready went high while the first key was still expanding");
		end
		load_key(golden[0]);
		wait_ready();
		for (int sel = 0; sel <= NUM_ROUNDS; sel++)
			check_select(0, sel);
		finish_test(5, "restart");

		for (int sel = NUM_ROUNDS + 1; sel < (1 << ROUND_IDX_W); sel++)
			check_select(0, sel);
		finish_test(6, "out-of-range select");

		$display("Checks passed %0d, errors %0d", check_count - err_count, err_count);
		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- src/key_block.sv
// AES-128 key schedule top; ready stays low from each load until its eleventh key is stored
`timescale 1ns/10ps

module key_block
	import aes_key_pkg::*;
(
	input  logic                   tb_clk,
	input  logic                   rst,
	input  logic                   load,
	input  aes_key_u               in,
	input  logic [ROUND_IDX_W-1:0] select,
	output logic                   ready,
	output aes_key_u               round_key,
	output aes_key_u               fround_key
);

	// Write port from expander into the store
	logic                   wr_en;
	logic [ROUND_IDX_W-1:0] wr_idx;
	aes_key_u               wr_key;

	// Expansion in progress
	logic                   busy;

	// Derives the schedule one round per clock
	key_expander i_expander (
		.tb_clk (tb_clk),
		.rst    (rst),
		.load   (load),
		.in     (in),
		.wr_en  (wr_en),
		.wr_idx (wr_idx),
		.wr_key (wr_key),
		.busy   (busy)
	);

	// Holds all eleven keys, serves both orders
	key_store i_store (
		.tb_clk     (tb_clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_key     (wr_key),
		.busy       (busy),
		.select     (select),
		.ready      (ready),
		.round_key  (round_key),
		.fround_key (fround_key)
	);

endmodule

//--- src/key_store.sv
// Outputs lag select by one cycle and are only meaningful while ready is high
`timescale 1ns/10ps

module key_store
	import aes_key_pkg::*;
(
	input  logic                   tb_clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  logic [ROUND_IDX_W-1:0] wr_idx,
	input  aes_key_u               wr_key,
	input  logic                   busy,
	input  logic [ROUND_IDX_W-1:0] select,
	output logic                   ready,
	output aes_key_u               round_key,
	output aes_key_u               fround_key
);

	aes_key_u               keys [0:NUM_KEYS-1];
	logic                   done;
	logic                   sel_ok;
	logic                   wr_ok;
	logic                   wr_last;
	logic [ROUND_IDX_W-1:0] f_idx;

	// Decryption order reads the mirrored index
	assign sel_ok = (select <= ROUND_IDX_W'(NUM_ROUNDS));
	assign f_idx = ROUND_IDX_W'(NUM_ROUNDS) - select;

	assign wr_ok = wr_en && (wr_idx <= ROUND_IDX_W'(NUM_ROUNDS));
	assign wr_last = wr_en && (wr_idx == ROUND_IDX_W'(NUM_ROUNDS));

	// Valid once any expansion has finished and none is running
	assign ready = done & ~busy;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_KEYS; i++)
				keys[i] <= '0;
			done <= 1'b0;
			round_key <= '0;
			fround_key <= '0;
		end
		else
		begin
			if (wr_ok)
				keys[wr_idx] <= wr_key;

			if (wr_last)
				done <= 1'b1;

			// Both ports read the same array, zero for indices past round 10
			if (sel_ok)
			begin
				round_key <= keys[select];
				fround_key <= keys[f_idx];
			end
			else
			begin
				round_key <= '0;
				fround_key <= '0;
			end
		end
	end

	// Expander never addresses past the last round key
	assert property (@(posedge tb_clk) disable iff (rst)
		wr_en |-> (wr_idx <= ROUND_IDX_W'(NUM_ROUNDS)));

endmodule

//--- src/key_expander.sv
// One round key per cycle; write outputs are combinational from load, a load always restarts
`timescale 1ns/10ps

module key_expander
	import aes_key_pkg::*;
(
	input  logic                   tb_clk,
	input  logic                   rst,
	input  logic                   load,
	input  aes_key_u               in,
	output logic                   wr_en,
	output logic [ROUND_IDX_W-1:0] wr_idx,
	output aes_key_u               wr_key,
	output logic                   busy
);

	aes_key_u               cur_key;
	aes_key_u               next_key;
	logic [ROUND_IDX_W-1:0] count;
	logic [ROUND_IDX_W-1:0] rc_idx;
	logic [7:0]             rcon;
	logic [31:0]            sub_word;
	logic                   last_round;

	// Count holds the index of the key being derived
	assign last_round = (count == ROUND_IDX_W'(NUM_ROUNDS));
	assign rc_idx = count - ROUND_IDX_W'(1);
	assign rcon = (busy && count != '0) ? RCON[rc_idx] : 8'h00;

	// RotWord and SubWord on the last word, round constant into its top byte
	assign sub_word = {
		SBOX[cur_key.b[13]] ^ rcon,
		SBOX[cur_key.b[14]],
		SBOX[cur_key.b[15]],
		SBOX[cur_key.b[12]]
	};

	// Word chain of the next round key
	always_comb
	begin
		next_key.w[0] = cur_key.w[0] ^ sub_word;
		next_key.w[1] = cur_key.w[1] ^ next_key.w[0];
		next_key.w[2] = cur_key.w[2] ^ next_key.w[1];
		next_key.w[3] = cur_key.w[3] ^ next_key.w[2];
	end

	// Key 0 is the cipher key itself, written in the load cycle
	assign wr_en = load | busy;
	assign wr_idx = load ? '0 : count;
	assign wr_key = load ? in : next_key;

	always_ff @(posedge tb_clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			count <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			count <= ROUND_IDX_W'(1);
		end
		else if (busy)
		begin
			if (last_round)
			begin
				busy <= 1'b0;
				count <= '0;
			end
			else
			begin
				count <= count + ROUND_IDX_W'(1);
			end
		end
	end

	// Working key follows every written key
	always_ff @(posedge tb_clk)
	begin
		if (wr_en)
			cur_key <= wr_key;
	end

	// Round counter stays inside the schedule
	assert property (@(posedge tb_clk) disable iff (rst)
		count <= ROUND_IDX_W'(NUM_ROUNDS));

	// Round writes step through the indices one at a time
	assert property (@(posedge tb_clk) disable iff (rst)
		(wr_en && !load) |-> (wr_idx == $past(wr_idx) + ROUND_IDX_W'(1)));

endmodule

//--- src/aes_key_pkg.sv
// AES-128 only; byte and word index 0 is the most significant part of the key, as in FIPS-197
package aes_key_pkg;

	// Round count and sizes of the round key schedule
	localparam int NUM_ROUNDS = 10;
	localparam int NUM_KEYS = NUM_ROUNDS + 1;
	localparam int ROUND_IDX_W = 4;

	// One 128-bit key seen as words for the XOR chain or as bytes for SubWord
	typedef union packed {
		logic [0:3][31:0] w;
		logic [0:15][7:0] b;
	} aes_key_u;

	// Round constants, entry 0 belongs to round 1
	localparam logic [7:0] RCON [0:NUM_ROUNDS-1] = '{
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// Forward S-box
	localparam logic [7:0] SBOX [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

endpackage
